/* Makefile */
SIM = verilator
TOP = tb_nn_classifier
FILELIST = verilog.f
OBJ_DIR = obj_dir
FLAGS = --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
LINT_FLAGS = --lint-only --timing --assert -Wall
# checker errors are counted by the testbench, which ends with its own verdict
RUN_FLAGS = +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* rtl/act_mem_arbiter.sv */
`timescale 1ns/1ps

module act_mem_arbiter (
	input logic clk,
	input logic reset,
	input logic eng_req,
	input logic eng_we,
	input nn_pkg::act_addr_t eng_addr,
	input nn_pkg::act_t eng_wdata,
	output nn_pkg::act_t eng_rdata,
	input logic host_req,
	input logic host_we,
	input nn_pkg::act_addr_t host_addr,
	input nn_pkg::act_t host_wdata,
	output logic host_ack,
	output nn_pkg::act_t host_rdata
);
	import nn_pkg::*;

	act_t mem [act_depth];
	act_t mem_q;
	act_addr_t mem_addr;
	act_t mem_wdata;
	logic mem_we;
	logic host_go;

	// host waits while the engine holds the port and while ack is still up
	assign host_go = host_req && !host_ack && !eng_req;

	always_comb begin
		if (eng_req) begin
			mem_addr = eng_addr;
			mem_we = eng_we;
			mem_wdata = eng_wdata;
		end else begin
			mem_addr = host_addr;
			mem_we = host_go && host_we;
			mem_wdata = host_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_we) begin
			mem[mem_addr] <= mem_wdata;
		end
		mem_q <= mem[mem_addr];
	end

	assign eng_rdata = mem_q;

	// read data held for the whole ack phase
	always_ff @(posedge clk) begin
		if (host_go) begin
			host_rdata <= mem[mem_addr];
		end
	end

	// wait, then ack after the access, release once req drops
	always_ff @(posedge clk) begin
		if (reset) begin
			host_ack <= 1'b0;
		end else if (host_go) begin
			host_ack <= 1'b1;
		end else if (!host_req) begin
			host_ack <= 1'b0;
		end
	end

endmodule

/* rtl/hard_sigmoid.sv */
`timescale 1ns/1ps

module hard_sigmoid (
	input logic clk,
	input logic reset,
	input logic sig_valid,
	input nn_pkg::sig_in_u sig_in,
	output nn_pkg::act_t sig_out
);
	import nn_pkg::*;

	logic signed [17:0] scaled;
	act_t result;

	// 0.5 + x/4, going from Q5.13 to Q4.12 takes one more shift
	always_comb begin
		scaled = (sig_in.raw >>> 3) + (act_one >>> 1);
		if (scaled < 0) begin
			result = '0;
		end else if (scaled > act_one) begin
			result = act_one;
		end else begin
			result = act_t'(scaled);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sig_out <= '0;
		end else if (sig_valid) begin
			sig_out <= result;
		end
	end

endmodule

/* rtl/layer_sequencer.sv */
`timescale 1ns/1ps

module layer_sequencer (
	input logic clk,
	input logic reset,
	input logic start_req,
	output logic start_ack,
	output nn_pkg::rom_addr_t rom_addr,
	output logic eng_req,
	output logic eng_we,
	output nn_pkg::act_addr_t eng_addr,
	output logic bias_load,
	output logic acc_en,
	output logic sig_valid,
	input nn_pkg::act_t sig_out,
	output nn_pkg::act_t eng_wdata
);
	import nn_pkg::*;

	logic [2:0] state;
	logic layer_cnt;
	logic [2:0] neuron_cnt;
	logic [2:0] weight_cnt;
	logic sig_phase;
	logic [2:0] n_neurons;
	logic [2:0] n_weights;
	act_addr_t read_base;
	act_addr_t write_base;
	rom_addr_t rom_base;
	logic last_weight;
	logic last_neuron;
	logic last_layer;
	logic neuron_done;

	// per layer sizes and bases
	always_comb begin
		if (layer_cnt == 1'b0) begin
			n_neurons = 3'(n_hidden);
			n_weights = 3'(n_inputs);
			read_base = '0;
			write_base = act_addr_t'(hidden_base);
			rom_base = '0;
		end else begin
			n_neurons = 3'(n_outputs);
			n_weights = 3'(n_hidden);
			read_base = act_addr_t'(hidden_base);
			write_base = act_addr_t'(output_base);
			rom_base = rom_addr_t'(layer1_rom_base);
		end
	end

	assign last_weight = (weight_cnt == n_weights - 3'd1);
	assign last_neuron = (neuron_cnt == n_neurons - 3'd1);
	assign last_layer = (layer_cnt == 1'(n_layers - 1));
	assign neuron_done = (state == st_write_back);

	// bias word of the neuron, weights follow it
	always_comb begin
		rom_addr = rom_base + rom_addr_t'(neuron_cnt) * rom_addr_t'(n_weights + 3'd1);
		if (state == st_accumulate) begin
			rom_addr = rom_addr + rom_addr_t'(weight_cnt) + 5'd1;
		end
	end

	always_comb begin
		eng_req = (state == st_accumulate) || neuron_done;
		eng_we = neuron_done;
		eng_addr = read_base + act_addr_t'(weight_cnt);
		if (neuron_done) begin
			eng_addr = write_base + act_addr_t'(neuron_cnt);
		end
	end

	assign eng_wdata = sig_out;
	assign start_ack = (state == st_finish);
	// second drain cycle, accumulator holds the final sum
	assign sig_valid = (state == st_drain) && sig_phase;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			layer_cnt <= 1'b0;
			neuron_cnt <= '0;
			weight_cnt <= '0;
			sig_phase <= 1'b0;
			bias_load <= 1'b0;
			acc_en <= 1'b0;
		end else begin
			// data comes back one cycle after the address
			bias_load <= (state == st_bias);
			acc_en <= (state == st_accumulate);
			case (state)
				st_idle: begin
					layer_cnt <= 1'b0;
					neuron_cnt <= '0;
					if (start_req) begin
						state <= st_bias;
					end
				end
				st_bias: begin
					weight_cnt <= '0;
					state <= st_accumulate;
				end
				st_accumulate: begin
					if (last_weight) begin
						sig_phase <= 1'b0;
						state <= st_drain;
					end else begin
						weight_cnt <= weight_cnt + 3'd1;
					end
				end
				st_drain: begin
					sig_phase <= 1'b1;
					if (sig_phase) begin
						state <= st_write_back;
					end
				end
				st_write_back: begin
					if (!last_neuron) begin
						neuron_cnt <= neuron_cnt + 3'd1;
						state <= st_bias;
					end else if (!last_layer) begin
						neuron_cnt <= '0;
						layer_cnt <= layer_cnt + 1'b1;
						state <= st_bias;
					end else begin
						state <= st_finish;
					end
				end
				st_finish: begin
					// hold ack until the host lets go
					if (!start_req) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

/* rtl/mac_unit.sv */
`timescale 1ns/1ps

module mac_unit (
	input logic clk,
	input logic reset,
	input logic bias_load,
	input logic acc_en,
	input nn_pkg::act_t act_data,
	input nn_pkg::act_t weight_data,
	output nn_pkg::sig_in_u sig_in
);
	import nn_pkg::*;

	acc_t acc;
	acc_t shifted;
	logic signed [31:0] product;
	sig_in_u narrow;

	// Q4.12 times Q4.12 gives Q8.24
	assign product = act_data * weight_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
		end else if (bias_load) begin
			// bias moved up to 24 fraction bits
			acc <= acc_t'(weight_data) <<< 12;
		end else if (acc_en) begin
			acc <= acc + acc_t'(product);
		end
	end

	// Q16.24 down to Q5.13, clamped to +-sig_max
	always_comb begin
		shifted = acc >>> 11;
		narrow.raw = shifted[17:0];
		sig_in = narrow;
		if (acc_t'(narrow.raw) != shifted || narrow.raw < -sig_max) begin
			sig_in.fields.sign = shifted[39];
			if (shifted[39]) begin
				sig_in.fields.int_part = 4'h0;
				sig_in.fields.frac = 13'd1;
			end else begin
				sig_in.fields.int_part = 4'hf;
				sig_in.fields.frac = 13'h1fff;
			end
		end
	end

endmodule

/* rtl/nn_classifier.sv */
`timescale 1ns/1ps

module nn_classifier (
	input logic clk,
	input logic reset,
	input logic start_req,
	input logic host_req,
	input logic host_we,
	input nn_pkg::act_addr_t host_addr,
	input nn_pkg::act_t host_wdata,
	output logic start_ack,
	output logic host_ack,
	output nn_pkg::act_t host_rdata
);
	import nn_pkg::*;

	rom_addr_t rom_addr;
	act_t rom_data;
	logic eng_req;
	logic eng_we;
	act_addr_t eng_addr;
	act_t eng_wdata;
	act_t eng_rdata;
	logic bias_load;
	logic acc_en;
	logic sig_valid;
	sig_in_u sig_in;
	act_t sig_out;

	layer_sequencer layer_sequencer_i (
		.clk(clk),
		.reset(reset),
		.start_req(start_req),
		.start_ack(start_ack),
		.rom_addr(rom_addr),
		.eng_req(eng_req),
		.eng_we(eng_we),
		.eng_addr(eng_addr),
		.bias_load(bias_load),
		.acc_en(acc_en),
		.sig_valid(sig_valid),
		.sig_out(sig_out),
		.eng_wdata(eng_wdata)
	);

	weight_rom weight_rom_i (
		.clk(clk),
		.rom_addr(rom_addr),
		.rom_data(rom_data)
	);

	act_mem_arbiter act_mem_arbiter_i (
		.clk(clk),
		.reset(reset),
		.eng_req(eng_req),
		.eng_we(eng_we),
		.eng_addr(eng_addr),
		.eng_wdata(eng_wdata),
		.eng_rdata(eng_rdata),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_ack(host_ack),
		.host_rdata(host_rdata)
	);

	// bias and weights both arrive on the rom data
	mac_unit mac_unit_i (
		.clk(clk),
		.reset(reset),
		.bias_load(bias_load),
		.acc_en(acc_en),
		.act_data(eng_rdata),
		.weight_data(rom_data),
		.sig_in(sig_in)
	);

	hard_sigmoid hard_sigmoid_i (
		.clk(clk),
		.reset(reset),
		.sig_valid(sig_valid),
		.sig_in(sig_in),
		.sig_out(sig_out)
	);

endmodule

/* rtl/nn_pkg.sv */
package nn_pkg;

	// layer sizes
	localparam int n_inputs = 4;
	localparam int n_hidden = 3;
	localparam int n_outputs = 2;
	localparam int n_layers = 2;

	// activation memory map, inputs start at word 0
	localparam int act_depth = 16;
	localparam int hidden_base = n_inputs;
	localparam int output_base = hidden_base + n_hidden;

	// per neuron the bias comes first, then one weight per input
	localparam int layer1_rom_base = n_hidden * (n_inputs + 1);
	localparam int rom_depth = layer1_rom_base + n_outputs * (n_hidden + 1);

	typedef logic [3:0] act_addr_t;
	typedef logic [4:0] rom_addr_t;

	// Q4.12 for activations, weights and biases
	typedef logic signed [15:0] act_t;
	// Q16.24 accumulator
	typedef logic signed [39:0] acc_t;

	// sigmoid input in Q5.13
	typedef union packed {
		logic signed [17:0] raw;
		struct packed {
			logic sign;
			logic [3:0] int_part;
			logic [12:0] frac;
		} fields;
	} sig_in_u;

	// 16.0 minus one lsb
	localparam logic signed [17:0] sig_max = 18'sh1ffff;
	localparam act_t act_one = 16'sd4096;

	// sequencer states
	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_bias = 3'd1;
	localparam logic [2:0] st_accumulate = 3'd2;
	localparam logic [2:0] st_drain = 3'd3;
	localparam logic [2:0] st_write_back = 3'd4;
	localparam logic [2:0] st_finish = 3'd5;

endpackage

/* rtl/weight_rom.sv */
`timescale 1ns/1ps

module weight_rom (
	input logic clk,
	input nn_pkg::rom_addr_t rom_addr,
	output nn_pkg::act_t rom_data
);
	import nn_pkg::*;

	act_t rom [rom_depth];

	// bias and weight table
	initial begin
		$readmemh("rtl/weights.hex", rom);
	end

	always_ff @(posedge clk) begin
		rom_data <= rom[rom_addr];
	end

endmodule

/* rtl/weights.hex */
// one 16-bit Q4.12 word per line, per neuron the bias then one weight per input
// hidden neurons 0..2 with four weights each, then output neurons 0..1 with three
0400
1000
F000
0800
F800
FC00
0C00
0400
E800
1800
7000
7000
7000
7000
7000
F000
2000
E000
1000
0800
D000
3000
F400

/* sim/nn_classifier_chk.sv */
`timescale 1ns/1ps

module nn_classifier_chk (
	input logic clk,
	input logic reset,
	input logic start_req,
	input logic start_ack,
	input logic host_req,
	input logic host_ack,
	input logic eng_req,
	input logic eng_we,
	input nn_pkg::act_t eng_wdata
);
	import nn_pkg::*;

	int fail_count = 0;

	// both acks low coming out of reset
	ack_after_reset: assert property (@(posedge clk) reset |=> !start_ack && !host_ack)
	else begin
		$error("an acknowledge is high right after reset");
		fail_count = fail_count + 1;
	end

	host_ack_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(host_ack) |-> $past(host_req))
	else begin
		$error("host_ack rose without host_req");
		fail_count = fail_count + 1;
	end

	host_ack_fall: assert property (@(posedge clk) disable iff (reset)
		$fell(host_ack) |-> !$past(host_req))
	else begin
		$error("host_ack fell while host_req was still high");
		fail_count = fail_count + 1;
	end

	start_ack_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(start_ack) |-> $past(start_req))
	else begin
		$error("start_ack rose without start_req");
		fail_count = fail_count + 1;
	end

	start_ack_fall: assert property (@(posedge clk) disable iff (reset)
		$fell(start_ack) |-> !$past(start_req))
	else begin
		$error("start_ack fell while start_req was still high");
		fail_count = fail_count + 1;
	end

	// sigmoid output lies in 0 .. 1.0
	write_range: assert property (@(posedge clk) disable iff (reset)
		eng_req && eng_we |-> !eng_wdata[15] && eng_wdata <= act_one)
	else begin
		$error("engine wrote an activation outside 0 to 1.0");
		fail_count = fail_count + 1;
	end

	// the engine writes only while a start request is pending
	idle_no_write: assert property (@(posedge clk) disable iff (reset)
		eng_req && eng_we |-> start_req && !start_ack)
	else begin
		$error("engine wrote memory while the sequencer was idle");
		fail_count = fail_count + 1;
	end

endmodule

/* sim/tb_nn_classifier.sv */
`timescale 1ns/1ps

module tb_nn_classifier;
	import nn_pkg::*;

	localparam int clk_period = 40;
	localparam int reset_cycles = 16;
	localparam int n_runs = 3;
	// a run takes about 40 cycles, a host access about 4
	localparam int run_cycles = 40;
	localparam int accesses_per_run = 14;
	localparam int access_cycles = 4;
	localparam int limit_cycles =
		4 * (reset_cycles + n_runs * (run_cycles + accesses_per_run * access_cycles));

	logic clk;
	logic reset;
	logic start_req;
	logic host_req;
	logic host_we;
	act_addr_t host_addr;
	act_t host_wdata;
	logic start_ack;
	logic host_ack;
	act_t host_rdata;

	act_t wts [rom_depth];
	act_t model [act_depth];
	logic [31:0] rng;

	nn_classifier nn_classifier_i (
		.clk(clk),
		.reset(reset),
		.start_req(start_req),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.start_ack(start_ack),
		.host_ack(host_ack),
		.host_rdata(host_rdata)
	);

	bind nn_classifier nn_classifier_chk chk_i (
		.clk(clk),
		.reset(reset),
		.start_req(start_req),
		.start_ack(start_ack),
		.host_req(host_req),
		.host_ack(host_ack),
		.eng_req(eng_req),
		.eng_we(eng_we),
		.eng_wdata(eng_wdata)
	);

	always #(clk_period / 2) clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// -2.0 up to just under 2.0
	function automatic act_t rand_act();
		rng = xorshift(rng);
		return act_t'($signed(rng[13:0]));
	endfunction

	// bias plus products, saturate to Q5.13, then 0.5 + x/4 clipped to 0..1
	function automatic act_t neuron(input int rom_idx, input int in_base, input int n_in);
		longint acc;
		longint x;
		acc = longint'(wts[rom_idx]) * 4096;
		for (int i = 0; i < n_in; i++) begin
			acc += longint'(model[in_base + i]) * longint'(wts[rom_idx + 1 + i]);
		end
		x = acc >>> 11;
		if (x > sig_max) begin
			x = sig_max;
		end else if (x < -sig_max) begin
			x = -sig_max;
		end
		x = (x >>> 3) + 2048;
		if (x < 0) begin
			x = 0;
		end else if (x > act_one) begin
			x = act_one;
		end
		return act_t'(x);
	endfunction

	task automatic model_network();
		for (int n = 0; n < n_hidden; n++) begin
			model[hidden_base + n] = neuron(n * (n_inputs + 1), 0, n_inputs);
		end
		for (int n = 0; n < n_outputs; n++) begin
			model[output_base + n] =
				neuron(layer1_rom_base + n * (n_hidden + 1), hidden_base, n_hidden);
		end
	endtask

	task automatic expect_equal(input string name, input act_t expected, input act_t actual);
		assert (actual === expected)
		else begin
			$display("mismatch at %0t ns: %s expected %0d actual %0d",
				$time, name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic write_word(input act_addr_t addr, input act_t data);
		@(negedge clk);
		host_req = 1'b1;
		host_we = 1'b1;
		host_addr = addr;
		host_wdata = data;
		do begin
			@(negedge clk);
		end while (!host_ack);
		host_req = 1'b0;
		while (host_ack) begin
			@(negedge clk);
		end
	endtask

	task automatic read_word(input act_addr_t addr, output act_t data);
		@(negedge clk);
		host_req = 1'b1;
		host_we = 1'b0;
		host_addr = addr;
		do begin
			@(negedge clk);
		end while (!host_ack);
		data = host_rdata;
		host_req = 1'b0;
		while (host_ack) begin
			@(negedge clk);
		end
	endtask

	task automatic start_run();
		@(negedge clk);
		start_req = 1'b1;
		do begin
			@(negedge clk);
		end while (!start_ack);
		start_req = 1'b0;
		while (start_ack) begin
			@(negedge clk);
		end
	endtask

	initial begin
		#(limit_cycles * clk_period);
		$display("watchdog expired after %0d cycles without the test finishing", limit_cycles);
		$display("SIMULATION FAILED");
		$fatal(1);
	end

	// a failed checker assertion ends the run at once
	always @(negedge clk) begin
		if (nn_classifier_i.chk_i.fail_count != 0) begin
			$display("a checker assertion failed before %0t ns", $time);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	end

	initial begin
		act_t data;
		act_t during_run;
		clk = 1'b0;
		reset = 1'b1;
		start_req = 1'b0;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		rng = 32'd12;
		$readmemh("rtl/weights.hex", wts);
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;

		for (int run = 0; run < n_runs; run++) begin
			for (int i = 0; i < n_inputs; i++) begin
				model[i] = rand_act();
				write_word(act_addr_t'(i), model[i]);
			end
			for (int i = 0; i < n_inputs; i++) begin
				read_word(act_addr_t'(i), data);
				expect_equal($sformatf("host_rdata[%0d]", i), model[i], data);
			end
			model_network();
			// host read competes with the running engine
			fork
				start_run();
				begin
					repeat (3) @(negedge clk);
					read_word(act_addr_t'(run), during_run);
				end
			join
			expect_equal($sformatf("host_rdata[%0d] during run", run), model[run], during_run);
			for (int n = 0; n < n_hidden; n++) begin
				read_word(act_addr_t'(hidden_base + n), data);
				expect_equal($sformatf("host_rdata[%0d] hidden", hidden_base + n),
					model[hidden_base + n], data);
			end
			for (int n = 0; n < n_outputs; n++) begin
				read_word(act_addr_t'(output_base + n), data);
				expect_equal($sformatf("host_rdata[%0d] output", output_base + n),
					model[output_base + n], data);
			end
		end

		@(negedge clk);
		if (nn_classifier_i.chk_i.fail_count != 0) begin
			$display("checker assertions failed %0d times", nn_classifier_i.chk_i.fail_count);
			$display("SIMULATION FAILED");
			$fatal(1);
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

/* verilog.f */
rtl/nn_pkg.sv
rtl/weight_rom.sv
rtl/act_mem_arbiter.sv
rtl/mac_unit.sv
rtl/hard_sigmoid.sv
rtl/layer_sequencer.sv
rtl/nn_classifier.sv
sim/nn_classifier_chk.sv
sim/tb_nn_classifier.sv
